//--- eth_pkg.sv
////////////////////////////////////////
// Ethernet frame types shared by the
// receive and transmit datapaths
////////////////////////////////////////
package eth_pkg;

    // Ethernet header, 14 bytes on the wire
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // One payload beat of a byte stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        // Frame marked bad by the source
        logic       user;
    } byte_beat_t;

    localparam logic [15:0] ethertype_ipv4 = 16'h0800;
    localparam logic [15:0] ethertype_arp  = 16'h0806;

endpackage

//--- ip_pkg.sv
////////////////////////////////////////
// IPv4 header and ARP field definitions
////////////////////////////////////////
package ip_pkg;

    // Parsed IPv4 header as handed to the user
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [47:0] eth_src_mac;
    } ip_hdr_t;

    localparam logic [15:0] arp_oper_request = 16'd1;
    localparam logic [15:0] arp_oper_reply   = 16'd2;

    // Ethernet hardware type, MAC and IPv4 address lengths
    localparam logic [15:0] arp_htype_eth = 16'd1;
    localparam logic [7:0]  arp_hlen      = 8'd6;
    localparam logic [7:0]  arp_plen      = 8'd4;

    localparam int unsigned arp_payload_bytes = 28;

endpackage

//--- eth_type_demux.sv
////////////////////////////////////////
// EtherType demux, ARP or IPv4 or drop
////////////////////////////////////////
`timescale 1ns/1ps

module eth_type_demux
    import eth_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  eth_hdr_t   in_hdr,
    input  logic       in_hdr_valid,
    output logic       in_hdr_ready,
    input  byte_beat_t in_pay,
    input  logic       in_pay_valid,
    output logic       in_pay_ready,
    output eth_hdr_t   arp_hdr,
    output logic       arp_hdr_valid,
    input  logic       arp_hdr_ready,
    output byte_beat_t arp_pay,
    output logic       arp_pay_valid,
    input  logic       arp_pay_ready,
    output eth_hdr_t   ip_hdr_out,
    output logic       ip_hdr_valid,
    input  logic       ip_hdr_ready,
    output byte_beat_t ip_pay,
    output logic       ip_pay_valid,
    input  logic       ip_pay_ready
);
    typedef enum logic [1:0] {sel_none, sel_arp, sel_ip} sel_t;

    sel_t hdr_sel;
    sel_t pay_sel;
    sel_t sel_q;
    logic in_frame;
    logic hdr_fire;
    logic pay_fire;
    logic pay_active;

    always_comb begin
        case (in_hdr.eth_type)
            ethertype_arp:  hdr_sel = sel_arp;
            ethertype_ipv4: hdr_sel = sel_ip;
            default:        hdr_sel = sel_none;
        endcase
    end

    // Header side, one header per frame
    assign arp_hdr       = in_hdr;
    assign ip_hdr_out    = in_hdr;
    assign arp_hdr_valid = in_hdr_valid && !in_frame && hdr_sel == sel_arp;
    assign ip_hdr_valid  = in_hdr_valid && !in_frame && hdr_sel == sel_ip;
    assign in_hdr_ready  = !in_frame && ((hdr_sel == sel_arp && arp_hdr_ready) ||
                                         (hdr_sel == sel_ip && ip_hdr_ready) ||
                                         hdr_sel == sel_none);
    assign hdr_fire      = in_hdr_valid && in_hdr_ready;

    // First beat may ride along with its header
    assign pay_active    = in_frame || hdr_fire;
    assign pay_sel       = in_frame ? sel_q : hdr_sel;

    assign arp_pay       = in_pay;
    assign ip_pay        = in_pay;
    assign arp_pay_valid = in_pay_valid && pay_active && pay_sel == sel_arp;
    assign ip_pay_valid  = in_pay_valid && pay_active && pay_sel == sel_ip;
    assign in_pay_ready  = pay_active && ((pay_sel == sel_arp && arp_pay_ready) ||
                                          (pay_sel == sel_ip && ip_pay_ready) ||
                                          pay_sel == sel_none);
    assign pay_fire      = in_pay_valid && in_pay_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_frame <= 1'b0;
            sel_q    <= sel_none;
        end else begin
            if (hdr_fire) begin
                sel_q <= hdr_sel;
            end
            if (pay_fire && in_pay.last) begin
                in_frame <= 1'b0;
            end else if (hdr_fire) begin
                in_frame <= 1'b1;
            end
        end
    end

endmodule

//--- arp_responder.sv
////////////////////////////////////////
// ARP responder, answers requests for
// the local IP address
////////////////////////////////////////
`timescale 1ns/1ps

module arp_responder
    import eth_pkg::*, ip_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  eth_hdr_t    in_hdr,
    input  logic        in_hdr_valid,
    output logic        in_hdr_ready,
    input  byte_beat_t  in_pay,
    input  logic        in_pay_valid,
    output logic        in_pay_ready,
    output eth_hdr_t    out_hdr,
    output logic        out_hdr_valid,
    input  logic        out_hdr_ready,
    output byte_beat_t  out_pay,
    output logic        out_pay_valid,
    input  logic        out_pay_ready,
    input  logic [47:0] local_mac,
    input  logic [31:0] local_ip,
    output logic        rx_error_early_termination
);
    typedef enum logic [1:0] {st_idle, st_read, st_reply_hdr, st_reply_pay} state_t;

    localparam logic [4:0] last_idx = 5'(arp_payload_bytes - 1);

    state_t       state;
    logic [4:0]   cnt;
    logic [223:0] rx_buf;
    logic [223:0] rx_next;
    logic [223:0] reply;
    logic [47:0]  req_eth_mac;
    logic [47:0]  req_mac;
    logic [31:0]  req_ip;
    logic         pay_fire;
    logic         req_match;

    assign in_hdr_ready = state == st_idle;
    assign in_pay_ready = state == st_read;
    assign pay_fire     = in_pay_valid && in_pay_ready;

    // Byte 0 ends up in the top byte once all 28 are in
    assign rx_next   = {rx_buf[215:0], in_pay.data};
    // Opcode at bytes 6-7, target IP at bytes 24-27
    assign req_match = cnt == last_idx && !in_pay.user &&
                       rx_next[175:160] == arp_oper_request &&
                       rx_next[31:0] == local_ip;

    assign reply = {arp_htype_eth, ethertype_ipv4, arp_hlen, arp_plen, arp_oper_reply,
                    local_mac, local_ip, req_mac, req_ip};

    assign out_hdr.dest_mac = req_eth_mac;
    assign out_hdr.src_mac  = local_mac;
    assign out_hdr.eth_type = ethertype_arp;
    assign out_hdr_valid    = state == st_reply_hdr;

    assign out_pay.data  = reply[(223 - 8 * cnt) -: 8];
    assign out_pay.last  = cnt == last_idx;
    assign out_pay.user  = 1'b0;
    assign out_pay_valid = state == st_reply_pay;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state                      <= st_idle;
            cnt                        <= '0;
            rx_error_early_termination <= 1'b0;
        end else begin
            rx_error_early_termination <= 1'b0;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (in_hdr_valid) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    if (pay_fire) begin
                        // Saturates past 28 so long frames never match
                        if (cnt != 5'(arp_payload_bytes)) begin
                            cnt <= cnt + 5'd1;
                        end
                        if (in_pay.last) begin
                            state                      <= req_match ? st_reply_hdr : st_idle;
                            rx_error_early_termination <= cnt < last_idx;
                        end
                    end
                end
                st_reply_hdr: begin
                    cnt <= '0;
                    if (out_hdr_ready) begin
                        state <= st_reply_pay;
                    end
                end
                default: begin
                    if (out_pay_ready) begin
                        cnt <= cnt + 5'd1;
                        if (out_pay.last) begin
                            state <= st_idle;
                        end
                    end
                end
            endcase
        end
    end

    // Frame contents, no reset
    always_ff @(posedge clk) begin
        if (in_hdr_valid && in_hdr_ready) begin
            req_eth_mac <= in_hdr.src_mac;
        end
        if (pay_fire) begin
            rx_buf <= rx_next;
            if (in_pay.last) begin
                req_mac <= rx_next[159:112];
                req_ip  <= rx_next[111:80];
            end
        end
    end

endmodule

//--- ip_rx_check.sv
////////////////////////////////////////
// IPv4 receive, header parse and checksum
////////////////////////////////////////
`timescale 1ns/1ps

module ip_rx_check
    import eth_pkg::*, ip_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  eth_hdr_t   in_hdr,
    input  logic       in_hdr_valid,
    output logic       in_hdr_ready,
    input  byte_beat_t in_pay,
    input  logic       in_pay_valid,
    output logic       in_pay_ready,
    output ip_hdr_t    out_hdr,
    output logic       out_hdr_valid,
    input  logic       out_hdr_ready,
    output byte_beat_t out_pay,
    output logic       out_pay_valid,
    input  logic       out_pay_ready,
    output logic       rx_error_invalid_header,
    output logic       rx_error_invalid_checksum,
    output logic       rx_error_early_termination
);
    typedef enum logic [1:0] {st_idle, st_header, st_payload, st_drop} state_t;

    state_t       state;
    logic [4:0]   cnt;
    logic [159:0] hdr_buf;
    logic [159:0] hdr_next;
    logic [19:0]  sum;
    logic [19:0]  sum_next;
    logic [16:0]  fold1;
    logic [15:0]  fold2;
    logic         hdr_ok;
    logic         csum_ok;
    logic         pay_fire;

    // No new header until the last beat of the previous frame has left
    assign in_hdr_ready = state == st_idle && !out_pay_valid;
    always_comb begin
        case (state)
            st_header:  in_pay_ready = 1'b1;
            st_drop:    in_pay_ready = 1'b1;
            st_payload: in_pay_ready = !out_hdr_valid && (!out_pay_valid || out_pay_ready);
            default:    in_pay_ready = 1'b0;
        endcase
    end
    assign pay_fire = in_pay_valid && in_pay_ready;

    // Even bytes are the high half of each 16-bit word
    assign hdr_next = {hdr_buf[151:0], in_pay.data};
    assign sum_next = sum + (cnt[0] ? {12'd0, in_pay.data} : {4'd0, in_pay.data, 8'd0});
    assign fold1    = {1'b0, sum_next[15:0]} + {13'd0, sum_next[19:16]};
    assign fold2    = fold1[15:0] + {15'd0, fold1[16]};
    assign csum_ok  = fold2 == 16'hffff;
    // Version 4, IHL 5
    assign hdr_ok   = hdr_next[159:152] == 8'h45;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state                      <= st_idle;
            cnt                        <= '0;
            sum                        <= '0;
            out_hdr_valid              <= 1'b0;
            out_pay_valid              <= 1'b0;
            rx_error_invalid_header    <= 1'b0;
            rx_error_invalid_checksum  <= 1'b0;
            rx_error_early_termination <= 1'b0;
        end else begin
            rx_error_invalid_header    <= 1'b0;
            rx_error_invalid_checksum  <= 1'b0;
            rx_error_early_termination <= 1'b0;
            if (out_hdr_valid && out_hdr_ready) begin
                out_hdr_valid <= 1'b0;
            end
            if (state == st_payload && pay_fire) begin
                out_pay_valid <= 1'b1;
            end else if (out_pay_ready) begin
                out_pay_valid <= 1'b0;
            end
            case (state)
                st_idle: begin
                    cnt <= '0;
                    sum <= '0;
                    if (in_hdr_valid && in_hdr_ready) begin
                        state <= st_header;
                    end
                end
                st_header: begin
                    if (pay_fire) begin
                        cnt <= cnt + 5'd1;
                        sum <= sum_next;
                        if (in_pay.last) begin
                            // Header cut short or no payload behind it
                            rx_error_early_termination <= 1'b1;
                            state                      <= st_idle;
                        end else if (cnt == 5'd19) begin
                            if (!hdr_ok) begin
                                rx_error_invalid_header <= 1'b1;
                                state                   <= st_drop;
                            end else if (!csum_ok) begin
                                rx_error_invalid_checksum <= 1'b1;
                                state                     <= st_drop;
                            end else begin
                                out_hdr_valid <= 1'b1;
                                state         <= st_payload;
                            end
                        end
                    end
                end
                default: begin
                    if (pay_fire && in_pay.last) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_hdr_valid && in_hdr_ready) begin
            out_hdr.eth_src_mac <= in_hdr.src_mac;
        end
        if (state == st_header && pay_fire) begin
            hdr_buf <= hdr_next;
            if (cnt == 5'd19) begin
                out_hdr.dscp      <= hdr_next[151:146];
                out_hdr.ecn       <= hdr_next[145:144];
                out_hdr.length    <= hdr_next[143:128];
                out_hdr.ttl       <= hdr_next[95:88];
                out_hdr.protocol  <= hdr_next[87:80];
                out_hdr.source_ip <= hdr_next[63:32];
                out_hdr.dest_ip   <= hdr_next[31:0];
            end
        end
        if (state == st_payload && pay_fire) begin
            out_pay <= in_pay;
        end
    end

endmodule

//--- eth_arb_mux.sv
////////////////////////////////////////
// Two-source Ethernet frame arbiter
////////////////////////////////////////
`timescale 1ns/1ps

module eth_arb_mux
    import eth_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  eth_hdr_t   a_hdr,
    input  logic       a_hdr_valid,
    output logic       a_hdr_ready,
    input  byte_beat_t a_pay,
    input  logic       a_pay_valid,
    output logic       a_pay_ready,
    input  eth_hdr_t   b_hdr,
    input  logic       b_hdr_valid,
    output logic       b_hdr_ready,
    input  byte_beat_t b_pay,
    input  logic       b_pay_valid,
    output logic       b_pay_ready,
    output eth_hdr_t   out_hdr,
    output logic       out_hdr_valid,
    input  logic       out_hdr_ready,
    output byte_beat_t out_pay,
    output logic       out_pay_valid,
    input  logic       out_pay_ready
);
    typedef enum logic [1:0] {st_idle, st_hdr, st_pay} state_t;

    state_t state;
    // Grant, low for source a
    logic   src_b;

    assign out_hdr       = src_b ? b_hdr : a_hdr;
    assign out_hdr_valid = state == st_hdr && (src_b ? b_hdr_valid : a_hdr_valid);
    assign a_hdr_ready   = state == st_hdr && !src_b && out_hdr_ready;
    assign b_hdr_ready   = state == st_hdr && src_b && out_hdr_ready;

    assign out_pay       = src_b ? b_pay : a_pay;
    assign out_pay_valid = state == st_pay && (src_b ? b_pay_valid : a_pay_valid);
    assign a_pay_ready   = state == st_pay && !src_b && out_pay_ready;
    assign b_pay_ready   = state == st_pay && src_b && out_pay_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            src_b <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (a_hdr_valid || b_hdr_valid) begin
                        src_b <= !a_hdr_valid;
                        state <= st_hdr;
                    end
                end
                st_hdr: begin
                    if (out_hdr_valid && out_hdr_ready) begin
                        state <= st_pay;
                    end
                end
                default: begin
                    // Grant held until the last beat leaves
                    if (out_pay_valid && out_pay_ready && out_pay.last) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

//--- ip_arp_core.sv
////////////////////////////////////////
// IPv4 receive and ARP reply front end
////////////////////////////////////////
`timescale 1ns/1ps

module ip_arp_core
    import eth_pkg::*, ip_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  eth_hdr_t    rx_hdr,
    input  logic        rx_hdr_valid,
    output logic        rx_hdr_ready,
    input  byte_beat_t  rx_pay,
    input  logic        rx_pay_valid,
    output logic        rx_pay_ready,
    input  eth_hdr_t    tx_hdr,
    input  logic        tx_hdr_valid,
    output logic        tx_hdr_ready,
    input  byte_beat_t  tx_pay,
    input  logic        tx_pay_valid,
    output logic        tx_pay_ready,
    output eth_hdr_t    out_hdr,
    output logic        out_hdr_valid,
    input  logic        out_hdr_ready,
    output byte_beat_t  out_pay,
    output logic        out_pay_valid,
    input  logic        out_pay_ready,
    output ip_hdr_t     ip_hdr,
    output logic        ip_hdr_valid,
    input  logic        ip_hdr_ready,
    output byte_beat_t  ip_pay,
    output logic        ip_pay_valid,
    input  logic        ip_pay_ready,
    input  logic [47:0] local_mac,
    input  logic [31:0] local_ip,
    output logic        rx_error_invalid_header,
    output logic        rx_error_invalid_checksum,
    output logic        rx_error_early_termination
);
    eth_hdr_t   arp_rx_hdr, ip_rx_hdr, arp_tx_hdr;
    byte_beat_t arp_rx_pay, ip_rx_pay, arp_tx_pay;
    logic       arp_rx_hdr_valid, arp_rx_hdr_ready, arp_rx_pay_valid, arp_rx_pay_ready;
    logic       ip_rx_hdr_valid, ip_rx_hdr_ready, ip_rx_pay_valid, ip_rx_pay_ready;
    logic       arp_tx_hdr_valid, arp_tx_hdr_ready, arp_tx_pay_valid, arp_tx_pay_ready;
    logic       arp_early, ip_early;

    assign rx_error_early_termination = arp_early || ip_early;

    eth_type_demux i_eth_type_demux (
        .clk(clk), .arst_n(arst_n),
        .in_hdr(rx_hdr), .in_hdr_valid(rx_hdr_valid), .in_hdr_ready(rx_hdr_ready),
        .in_pay(rx_pay), .in_pay_valid(rx_pay_valid), .in_pay_ready(rx_pay_ready),
        .arp_hdr(arp_rx_hdr), .arp_hdr_valid(arp_rx_hdr_valid),
        .arp_hdr_ready(arp_rx_hdr_ready),
        .arp_pay(arp_rx_pay), .arp_pay_valid(arp_rx_pay_valid),
        .arp_pay_ready(arp_rx_pay_ready),
        .ip_hdr_out(ip_rx_hdr), .ip_hdr_valid(ip_rx_hdr_valid), .ip_hdr_ready(ip_rx_hdr_ready),
        .ip_pay(ip_rx_pay), .ip_pay_valid(ip_rx_pay_valid), .ip_pay_ready(ip_rx_pay_ready)
    );

    arp_responder i_arp_responder (
        .clk(clk), .arst_n(arst_n),
        .in_hdr(arp_rx_hdr), .in_hdr_valid(arp_rx_hdr_valid), .in_hdr_ready(arp_rx_hdr_ready),
        .in_pay(arp_rx_pay), .in_pay_valid(arp_rx_pay_valid), .in_pay_ready(arp_rx_pay_ready),
        .out_hdr(arp_tx_hdr), .out_hdr_valid(arp_tx_hdr_valid),
        .out_hdr_ready(arp_tx_hdr_ready),
        .out_pay(arp_tx_pay), .out_pay_valid(arp_tx_pay_valid),
        .out_pay_ready(arp_tx_pay_ready),
        .local_mac(local_mac), .local_ip(local_ip),
        .rx_error_early_termination(arp_early)
    );

    ip_rx_check i_ip_rx_check (
        .clk(clk), .arst_n(arst_n),
        .in_hdr(ip_rx_hdr), .in_hdr_valid(ip_rx_hdr_valid), .in_hdr_ready(ip_rx_hdr_ready),
        .in_pay(ip_rx_pay), .in_pay_valid(ip_rx_pay_valid), .in_pay_ready(ip_rx_pay_ready),
        .out_hdr(ip_hdr), .out_hdr_valid(ip_hdr_valid), .out_hdr_ready(ip_hdr_ready),
        .out_pay(ip_pay), .out_pay_valid(ip_pay_valid), .out_pay_ready(ip_pay_ready),
        .rx_error_invalid_header(rx_error_invalid_header),
        .rx_error_invalid_checksum(rx_error_invalid_checksum),
        .rx_error_early_termination(ip_early)
    );

    // ARP replies take priority over user frames
    eth_arb_mux i_eth_arb_mux (
        .clk(clk), .arst_n(arst_n),
        .a_hdr(arp_tx_hdr), .a_hdr_valid(arp_tx_hdr_valid), .a_hdr_ready(arp_tx_hdr_ready),
        .a_pay(arp_tx_pay), .a_pay_valid(arp_tx_pay_valid), .a_pay_ready(arp_tx_pay_ready),
        .b_hdr(tx_hdr), .b_hdr_valid(tx_hdr_valid), .b_hdr_ready(tx_hdr_ready),
        .b_pay(tx_pay), .b_pay_valid(tx_pay_valid), .b_pay_ready(tx_pay_ready),
        .out_hdr(out_hdr), .out_hdr_valid(out_hdr_valid), .out_hdr_ready(out_hdr_ready),
        .out_pay(out_pay), .out_pay_valid(out_pay_valid), .out_pay_ready(out_pay_ready)
    );

endmodule

//--- tb_ip_arp_core.sv
////////////////////////////////////////
// Testbench for the IPv4/ARP front end
////////////////////////////////////////
`timescale 1ns/1ps

module tb_ip_arp_core
    import eth_pkg::*, ip_pkg::*;
;
    localparam int frame_count = 14;

    logic        clk;
    logic        arst_n = 1'b0;
    eth_hdr_t    rx_hdr = '0;
    logic        rx_hdr_valid = 1'b0;
    logic        rx_hdr_ready;
    byte_beat_t  rx_pay = '0;
    logic        rx_pay_valid = 1'b0;
    logic        rx_pay_ready;
    eth_hdr_t    tx_hdr = '0;
    logic        tx_hdr_valid = 1'b0;
    logic        tx_hdr_ready;
    byte_beat_t  tx_pay = '0;
    logic        tx_pay_valid = 1'b0;
    logic        tx_pay_ready;
    eth_hdr_t    out_hdr;
    logic        out_hdr_valid;
    logic        out_hdr_ready = 1'b0;
    byte_beat_t  out_pay;
    logic        out_pay_valid;
    logic        out_pay_ready = 1'b0;
    ip_hdr_t     ip_hdr;
    logic        ip_hdr_valid;
    logic        ip_hdr_ready = 1'b0;
    byte_beat_t  ip_pay;
    logic        ip_pay_valid;
    logic        ip_pay_ready = 1'b0;
    logic [47:0] local_mac = 48'h02_00_00_00_00_01;
    logic [31:0] local_ip = 32'hc0a8_0164;
    logic        rx_error_invalid_header;
    logic        rx_error_invalid_checksum;
    logic        rx_error_early_termination;

    integer     seed = 32'h3dbf4acb;
    int         errors = 0;
    int         n_hdr_err = 0;
    int         n_csum_err = 0;
    int         n_early_err = 0;
    logic [7:0] rx_buf [0:127];
    int         rx_len;
    logic       rx_user;
    eth_hdr_t   rx_eth;
    logic [7:0] tx_buf [0:127];
    int         tx_len;
    logic       tx_user;
    eth_hdr_t   tx_eth;
    logic       out_busy = 1'b0;
    logic       out_is_arp = 1'b0;

    // Expected results per output source
    eth_hdr_t   arp_hdr_q [$];
    byte_beat_t arp_beat_q [$];
    eth_hdr_t   tx_hdr_q [$];
    byte_beat_t tx_beat_q [$];
    ip_hdr_t    ip_hdr_q [$];
    byte_beat_t ip_beat_q [$];

    ip_arp_core i_ip_arp_core (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        out_hdr_ready <= 1'($random(seed));
        out_pay_ready <= 1'($random(seed));
        ip_hdr_ready  <= 1'($random(seed));
        ip_pay_ready  <= 1'($random(seed));
    end

    function automatic void check_val(string name, logic [159:0] got, logic [159:0] exp);
        assert (got == exp) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endfunction

    function automatic void report(string what);
        $display("ERROR %s", what);
        errors++;
    endfunction

    // Reference for an ARP request and, if it targets us, the reply
    function automatic void build_arp(logic [47:0] sha, logic [31:0] spa, logic [31:0] tpa);
        logic [223:0] p;
        eth_hdr_t     h;
        p = {16'd1, 16'h0800, 8'd6, 8'd4, 16'd1, sha, spa, 48'd0, tpa};
        for (int i = 0; i < 28; i++) begin
            rx_buf[i] = p[223 - 8 * i -: 8];
        end
        rx_len  = 28;
        rx_user = 1'b0;
        rx_eth  = '{dest_mac: 48'hffff_ffff_ffff, src_mac: sha, eth_type: 16'h0806};
        if (tpa == local_ip) begin
            h = '{dest_mac: sha, src_mac: local_mac, eth_type: 16'h0806};
            arp_hdr_q.push_back(h);
            p = {16'd1, 16'h0800, 8'd6, 8'd4, 16'd2, local_mac, local_ip, sha, spa};
            for (int i = 0; i < 28; i++) begin
                arp_beat_q.push_back({p[223 - 8 * i -: 8], i == 27, 1'b0});
            end
        end
    endfunction

    // Ones-complement checksum over header bytes 0 to 19
    function automatic logic [15:0] ip_checksum();
        logic [31:0] s;
        s = 0;
        for (int i = 0; i < 20; i += 2) begin
            s += {16'd0, rx_buf[i], rx_buf[i + 1]};
        end
        while (s[31:16] != 0) begin
            s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
        end
        return ~s[15:0];
    endfunction

    // IPv4 frame truncated to cut bytes when cut is nonzero
    // Bad or cut frames expect no ip output
    function automatic void build_ip(logic [7:0] ver_ihl, logic [7:0] tos, logic [31:0] src,
                                     int paylen, logic bad_csum, logic user, int cut);
        logic [15:0] csum;
        logic [15:0] total;
        ip_hdr_t     h;
        total = 16'(20 + paylen);
        rx_buf[0] = ver_ihl;
        rx_buf[1] = tos;
        {rx_buf[2], rx_buf[3]} = total;
        {rx_buf[4], rx_buf[5], rx_buf[6], rx_buf[7]} = 32'h1c46_4000;
        rx_buf[8] = 8'd64;
        rx_buf[9] = 8'd17;
        {rx_buf[10], rx_buf[11]} = 16'h0000;
        {rx_buf[12], rx_buf[13], rx_buf[14], rx_buf[15]} = src;
        {rx_buf[16], rx_buf[17], rx_buf[18], rx_buf[19]} = local_ip;
        csum = ip_checksum() ^ (bad_csum ? 16'h0100 : 16'h0000);
        {rx_buf[10], rx_buf[11]} = csum;
        for (int i = 0; i < paylen; i++) begin
            rx_buf[20 + i] = 8'(i * 7 + 3);
        end
        rx_len  = cut > 0 ? cut : 20 + paylen;
        rx_user = user;
        rx_eth  = '{dest_mac: local_mac, src_mac: 48'h0a_bc_00_00_00_33, eth_type: 16'h0800};
        if (ver_ihl == 8'h45 && !bad_csum && cut == 0) begin
            h = '{dscp: tos[7:2], ecn: tos[1:0], length: total, ttl: 8'd64, protocol: 8'd17,
                  source_ip: src, dest_ip: local_ip, eth_src_mac: rx_eth.src_mac};
            ip_hdr_q.push_back(h);
            for (int i = 0; i < paylen; i++) begin
                ip_beat_q.push_back({rx_buf[20 + i], i == paylen - 1, user && i == paylen - 1});
            end
        end
    endfunction

    function automatic void build_tx(int idx, int len, logic user);
        tx_eth = '{dest_mac: 48'h0a_00_00_00_10_00 + 48'(idx), src_mac: local_mac,
                   eth_type: 16'h88b5};
        tx_len  = len;
        tx_user = user;
        tx_hdr_q.push_back(tx_eth);
        for (int i = 0; i < len; i++) begin
            tx_buf[i] = 8'($random(seed));
            tx_beat_q.push_back({tx_buf[i], i == len - 1, user && i == len - 1});
        end
    endfunction

    // Ready sampled at the falling edge
    // The transfer happens on the next rising edge
    task automatic send_rx();
        rx_hdr       <= rx_eth;
        rx_hdr_valid <= 1'b1;
        do @(negedge clk); while (!rx_hdr_ready);
        @(posedge clk);
        rx_hdr_valid <= 1'b0;
        for (int i = 0; i < rx_len; i++) begin
            rx_pay       <= {rx_buf[i], i == rx_len - 1, rx_user && i == rx_len - 1};
            rx_pay_valid <= 1'b1;
            do @(negedge clk); while (!rx_pay_ready);
            @(posedge clk);
        end
        rx_pay_valid <= 1'b0;
    endtask

    task automatic send_tx();
        tx_hdr       <= tx_eth;
        tx_hdr_valid <= 1'b1;
        do @(negedge clk); while (!tx_hdr_ready);
        @(posedge clk);
        tx_hdr_valid <= 1'b0;
        for (int i = 0; i < tx_len; i++) begin
            tx_pay       <= {tx_buf[i], i == tx_len - 1, tx_user && i == tx_len - 1};
            tx_pay_valid <= 1'b1;
            do @(negedge clk); while (!tx_pay_ready);
            @(posedge clk);
        end
        tx_pay_valid <= 1'b0;
    endtask

    // All outputs sampled mid-cycle against the queues
    always @(negedge clk) begin
        if (rx_error_invalid_header) n_hdr_err++;
        if (rx_error_invalid_checksum) n_csum_err++;
        if (rx_error_early_termination) n_early_err++;
        if (out_hdr_valid && out_hdr_ready) begin
            assert (!out_busy) else report("out header started inside another frame");
            out_busy   = 1'b1;
            out_is_arp = out_hdr.eth_type == 16'h0806;
            if (out_is_arp && arp_hdr_q.size() > 0) begin
                check_val("out_hdr", 160'(out_hdr), 160'(arp_hdr_q.pop_front()));
            end else if (!out_is_arp && tx_hdr_q.size() > 0) begin
                check_val("out_hdr", 160'(out_hdr), 160'(tx_hdr_q.pop_front()));
            end else begin
                report("unexpected frame header on out");
            end
        end
        if (out_pay_valid && out_pay_ready) begin
            assert (out_busy) else report("out payload beat outside a frame");
            if (out_is_arp && arp_beat_q.size() > 0) begin
                check_val("out_pay", 160'(out_pay), 160'(arp_beat_q.pop_front()));
            end else if (!out_is_arp && tx_beat_q.size() > 0) begin
                check_val("out_pay", 160'(out_pay), 160'(tx_beat_q.pop_front()));
            end else begin
                report("unexpected payload beat on out");
            end
            if (out_pay.last) out_busy = 1'b0;
        end
        if (ip_hdr_valid && ip_hdr_ready) begin
            if (ip_hdr_q.size() > 0) begin
                check_val("ip_hdr", 160'(ip_hdr), 160'(ip_hdr_q.pop_front()));
            end else begin
                report("unexpected header on ip");
            end
        end
        if (ip_pay_valid && ip_pay_ready) begin
            if (ip_beat_q.size() > 0) begin
                check_val("ip_pay", 160'(ip_pay), 160'(ip_beat_q.pop_front()));
            end else begin
                report("unexpected payload beat on ip");
            end
        end
    end

    initial begin
        repeat (10 + 200 * frame_count) @(posedge clk);
        $display("ERROR timeout, the DUT stopped making progress");
        $display("tests failed");
        $finish;
    end

    initial begin
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        // ARP request for us, then one for another host, then an unknown type
        build_arp(48'h0a_00_00_00_00_07, 32'hc0a8_0107, local_ip);
        send_rx();
        build_arp(48'h0a_00_00_00_00_08, 32'hc0a8_0108, 32'hc0a8_0199);
        send_rx();
        build_arp(48'h0a_00_00_00_00_09, 32'hc0a8_0109, local_ip);
        rx_eth.eth_type = 16'h88cc;
        arp_hdr_q.delete();
        arp_beat_q.delete();
        send_rx();
        // Good IPv4 frames then checksum and IHL errors
        build_ip(8'h45, 8'hb9, 32'hc0a8_0150, 10, 1'b0, 1'b1, 0);
        send_rx();
        build_ip(8'h45, 8'h00, 32'hc0a8_0151, 1, 1'b0, 1'b0, 0);
        send_rx();
        build_ip(8'h45, 8'h00, 32'hc0a8_0152, 8, 1'b1, 1'b0, 0);
        send_rx();
        build_ip(8'h46, 8'h00, 32'hc0a8_0153, 8, 1'b0, 1'b0, 0);
        send_rx();
        // ARP replies racing user frames
        fork
            for (int k = 0; k < 3; k++) begin
                build_arp(48'h0a_00_00_00_01_00 + 48'(k), 32'hc0a8_0120 + k, local_ip);
                send_rx();
            end
            for (int k = 0; k < 3; k++) begin
                build_tx(k, 6 + 9 * k, k == 1);
                send_tx();
            end
        join
        // Frame that ends inside its IPv4 header
        build_ip(8'h45, 8'h00, 32'hc0a8_0154, 8, 1'b0, 1'b0, 12);
        send_rx();
        while (arp_beat_q.size() != 0 || tx_beat_q.size() != 0 || ip_beat_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (50) @(posedge clk);
        assert (n_csum_err == 1) else report("checksum error pulse count wrong");
        assert (n_hdr_err == 1) else report("header error pulse count wrong");
        assert (n_early_err == 1) else report("early termination pulse count wrong");
        $display("errors %0d, header errors %0d, checksum errors %0d, early terminations %0d",
                 errors, n_hdr_err, n_csum_err, n_early_err);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- flist.f
eth_pkg.sv
ip_pkg.sv
eth_type_demux.sv
arp_responder.sv
ip_rx_check.sv
eth_arb_mux.sv
ip_arp_core.sv
tb_ip_arp_core.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f flist.f --top-module tb_ip_arp_core -o sim_tb
output=$(./obj_dir/sim_tb)
echo "$output"
if echo "$output" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi
